/* verilog/slm_bridge_pkg.sv */
// shared types and parameter defaults for the bridge; the fifo depth must stay a power of two
package slm_bridge_pkg;

  //////////////////////////////////////////////////////////////////////
  // data types
  //////////////////////////////////////////////////////////////////////

  // one byte on either serial link
  typedef logic [7:0] byte_t;

  // one spi write
  // addr sits in the upper byte so it leaves first
  typedef struct packed {
    byte_t addr;
    byte_t data;
  } spi_frame_t;

  // sck cycles per frame
  localparam int SPI_FRAME_BITS = $bits(spi_frame_t);

  //////////////////////////////////////////////////////////////////////
  // parameter defaults
  //////////////////////////////////////////////////////////////////////

  // 50 MHz sys_clk at 115200 baud
  localparam int DEF_CLKS_PER_BIT = 434;

  // sys_clk cycles per half sck period
  localparam int DEF_SPI_HALF_CLKS = 4;

  // reply fifo entries, power of two only
  localparam int DEF_FIFO_DEPTH = 4;

  // 10 cycles of slm reset is 200 ns at 50 MHz
  // slm needs at least 100 ns
  localparam int DEF_RESET_HOLD = 10;

endpackage

/* verilog/uart_rx.sv */
// 8N1 only with CLKS_PER_BIT of at least 2; a frame with a low stop bit is dropped silently
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = slm_bridge_pkg::DEF_CLKS_PER_BIT
) (
  input  logic                  sys_clk_i,
  input  logic                  reset_i,
  input  logic                  rx_serial_i,
  output logic                  rx_valid_o,
  output slm_bridge_pkg::byte_t rx_byte_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'((CLKS_PER_BIT - 1) / 2);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t        state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_idx_q;
  logic [1:0]       sync_q;
  logic             rx_s;
  logic             bit_done;

  // two flops against metastability
  // line idles high
  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rx_serial_i};
    end
  end

  assign rx_s     = sync_q[1];
  assign bit_done = (clk_cnt_q == LAST_CNT);

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      state_q    <= RX_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      clk_cnt_q  <= clk_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (!rx_s) begin
            state_q <= RX_START;
          end
        end
        // recheck at mid start bit, a glitch goes back to idle
        RX_START: begin
          if (clk_cnt_q == MID_CNT) begin
            clk_cnt_q <= '0;
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        // counter now wraps at mid-bit
        RX_DATA: begin
          if (bit_done) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (bit_done) begin
            // good stop bit only
            rx_valid_o <= rx_s;
            state_q    <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge sys_clk_i) begin
    if (state_q == RX_DATA && bit_done) begin
      rx_byte_o <= {rx_s, rx_byte_o[7:1]};
    end
  end

endmodule

/* verilog/uart_tx.sv */
// 8N1 only with CLKS_PER_BIT of at least 2; start must only be pulsed while busy is low
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = slm_bridge_pkg::DEF_CLKS_PER_BIT
) (
  input  logic                  sys_clk_i,
  input  logic                  reset_i,
  input  logic                  tx_start_i,
  input  slm_bridge_pkg::byte_t tx_byte_i,
  output logic                  tx_busy_o,
  output logic                  tx_serial_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t             state_q;
  logic [CNT_W-1:0]      clk_cnt_q;
  logic [2:0]            bit_idx_q;
  slm_bridge_pkg::byte_t shift_q;
  logic                  bit_done;

  assign bit_done  = (clk_cnt_q == LAST_CNT);
  assign tx_busy_o = (state_q != TX_IDLE);

  // serial pin is registered so it never glitches
  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      state_q     <= TX_IDLE;
      clk_cnt_q   <= '0;
      bit_idx_q   <= '0;
      tx_serial_o <= 1'b1;
    end else begin
      // bit timer runs in every state but idle
      clk_cnt_q <= (state_q == TX_IDLE || bit_done) ? '0 : clk_cnt_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          bit_idx_q <= '0;
          if (tx_start_i) begin
            state_q     <= TX_START;
            tx_serial_o <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_done) begin
            state_q     <= TX_DATA;
            tx_serial_o <= shift_q[0];
          end
        end
        // next bit sits at index 1 before the shift lands
        TX_DATA: begin
          if (bit_done) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q     <= TX_STOP;
              tx_serial_o <= 1'b1;
            end else begin
              tx_serial_o <= shift_q[1];
            end
          end
        end
        // busy holds to the end of the stop bit
        TX_STOP: begin
          if (bit_done) begin
            state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // byte latched on start, lsb first
  always_ff @(posedge sys_clk_i) begin
    if (state_q == TX_IDLE && tx_start_i) begin
      shift_q <= tx_byte_i;
    end else if (state_q == TX_DATA && bit_done) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  // the controller must wait for idle
  a_no_start_busy: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    tx_start_i |-> !tx_busy_o)
    else $error("uart start while transmitter busy");

endmodule

/* verilog/spi_master.sv */
// mode 0 writes of SPI_FRAME_BITS bits only; a start pulse during busy is ignored
`timescale 1ns/1ps

module spi_master #(
  parameter int SPI_HALF_CLKS = slm_bridge_pkg::DEF_SPI_HALF_CLKS
) (
  input  logic                       sys_clk_i,
  input  logic                       reset_i,
  input  logic                       start_i,
  input  slm_bridge_pkg::spi_frame_t frame_i,
  output logic                       busy_o,
  output logic                       sen_o,
  output logic                       sck_o,
  output logic                       mosi_o,
  input  logic                       miso_i,
  output slm_bridge_pkg::byte_t      rx_byte_o
);

  localparam int FRAME_BITS = slm_bridge_pkg::SPI_FRAME_BITS;
  localparam int HALF_W     = $clog2(SPI_HALF_CLKS + 1);
  localparam int BIT_W      = $clog2(FRAME_BITS);
  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(SPI_HALF_CLKS - 1);
  localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(FRAME_BITS - 1);

  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_FINISH} spi_state_t;

  spi_state_t            state_q;
  logic [HALF_W-1:0]     half_cnt_q;
  logic [BIT_W-1:0]      bit_cnt_q;
  logic [FRAME_BITS-1:0] tx_q;
  logic                  half_done;

  assign half_done = (half_cnt_q == HALF_LAST);
  assign busy_o    = (state_q != SPI_IDLE);

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      state_q    <= SPI_IDLE;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      sen_o      <= 1'b1;
      sck_o      <= 1'b0;
    end else begin
      half_cnt_q <= (state_q == SPI_IDLE || half_done) ? '0 : half_cnt_q + 1'b1;
      case (state_q)
        SPI_IDLE: begin
          bit_cnt_q <= '0;
          if (start_i) begin
            sen_o   <= 1'b0;
            state_q <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_done) begin
            sck_o <= ~sck_o;
            // falling edge closes a bit
            if (sck_o) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == BIT_LAST) begin
                state_q <= SPI_FINISH;
              end
            end
          end
        end
        // half period of hold before sen rises
        // busy drops a cycle later
        SPI_FINISH: begin
          if (sen_o) begin
            state_q <= SPI_IDLE;
          end else if (half_done) begin
            sen_o <= 1'b1;
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // shift registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk_i) begin
    if (state_q == SPI_IDLE && start_i) begin
      tx_q <= frame_i;
    end else if (state_q == SPI_SHIFT && half_done && sck_o) begin
      // mosi moves on the falling edge
      tx_q <= {tx_q[FRAME_BITS-2:0], 1'b0};
    end
    // miso taken on the rising edge
    // last 8 bits left are the data phase
    if (state_q == SPI_SHIFT && half_done && !sck_o) begin
      rx_byte_o <= {rx_byte_o[6:0], miso_i};
    end
  end

  // msb first, quiet while deselected
  assign mosi_o = tx_q[FRAME_BITS-1] & ~sen_o;

  // sck only toggles inside the select window
  a_sck_in_window: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    sck_o |-> !sen_o)
    else $error("sck high while sen deasserted");

endmodule

/* verilog/reply_fifo.sv */
// DEPTH must be a power of two; a write when full or a read when empty is ignored
`timescale 1ns/1ps

module reply_fifo #(
  parameter int DEPTH = slm_bridge_pkg::DEF_FIFO_DEPTH
) (
  input  logic                  sys_clk_i,
  input  logic                  reset_i,
  input  logic                  wr_en_i,
  input  slm_bridge_pkg::byte_t wr_data_i,
  input  logic                  rd_en_i,
  output slm_bridge_pkg::byte_t rd_data_o,
  output logic                  full_o,
  output logic                  empty_o
);

  localparam int AW = $clog2(DEPTH);

  slm_bridge_pkg::byte_t mem_q [DEPTH];
  // extra msb tells full from empty
  logic [AW:0]           wr_ptr_q;
  logic [AW:0]           rd_ptr_q;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en_i && !full_o) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en_i && !empty_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // storage and read data, valid the cycle after rd_en
  always_ff @(posedge sys_clk_i) begin
    if (wr_en_i && !full_o) begin
      mem_q[wr_ptr_q[AW-1:0]] <= wr_data_i;
    end
    if (rd_en_i && !empty_o) begin
      rd_data_o <= mem_q[rd_ptr_q[AW-1:0]];
    end
  end

  // the controller checks both flags before driving the enables
  a_no_overflow: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    wr_en_i |-> !full_o)
    else $error("fifo write while full");

  a_no_underflow: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    rd_en_i |-> !empty_o)
    else $error("fifo read while empty");

endmodule

/* verilog/bridge_ctrl.sv */
// bytes pair strictly by count since reset; replies arriving with the fifo full are lost
`timescale 1ns/1ps

module bridge_ctrl #(
  parameter int RESET_HOLD = slm_bridge_pkg::DEF_RESET_HOLD
) (
  input  logic                       sys_clk_i,
  input  logic                       reset_i,
  // uart receiver side
  input  logic                       rx_valid_i,
  input  slm_bridge_pkg::byte_t      rx_byte_i,
  // spi master side
  input  logic                       spi_busy_i,
  output slm_bridge_pkg::spi_frame_t spi_frame_o,
  output logic                       spi_start_o,
  // reply fifo side
  input  logic                       fifo_full_i,
  input  logic                       fifo_empty_i,
  output logic                       fifo_wr_o,
  output logic                       fifo_rd_o,
  // uart transmitter side
  input  logic                       tx_busy_i,
  output logic                       tx_start_o,
  // slm reset line
  output logic                       slm_reset_n_o
);

  localparam int HOLD_W = $clog2(RESET_HOLD + 1);

  // high while a first byte waits for its partner
  logic              odd_byte_q;
  // busy delayed one cycle for edge detect
  logic              spi_busy_q;
  // fifo read issued last cycle
  logic              rd_q;
  // cycles of slm reset still to go
  logic [HOLD_W-1:0] hold_cnt_q;

  //////////////////////////////////////////////////////////////////////
  // host bytes to spi frames
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      odd_byte_q  <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      spi_start_o <= 1'b0;
      if (rx_valid_i) begin
        odd_byte_q  <= ~odd_byte_q;
        // second byte of a pair fires the write
        spi_start_o <= odd_byte_q;
      end
    end
  end

  // previous byte moves to addr and the new byte to data
  // frame is already updated when the start pulse goes out
  always_ff @(posedge sys_clk_i) begin
    if (rx_valid_i) begin
      spi_frame_o.addr <= spi_frame_o.data;
      spi_frame_o.data <= rx_byte_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // replies through the fifo to the uart
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      spi_busy_q <= 1'b0;
      rd_q       <= 1'b0;
    end else begin
      spi_busy_q <= spi_busy_i;
      rd_q       <= fifo_rd_o;
    end
  end

  // push on the first idle cycle after a frame
  // reply byte is final by then
  assign fifo_wr_o = spi_busy_q & ~spi_busy_i & ~fifo_full_i;

  // pop only into an idle transmitter
  // skip a cycle so tx_busy has time to rise
  assign fifo_rd_o = ~fifo_empty_i & ~tx_busy_i & ~rd_q;

  // fifo data is registered so start one cycle late
  assign tx_start_o = rd_q;

  //////////////////////////////////////////////////////////////////////
  // slm reset stretcher
  //////////////////////////////////////////////////////////////////////

  // reload on every reset, then count down to zero
  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      hold_cnt_q <= HOLD_W'(RESET_HOLD);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // held low until the count runs out
  assign slm_reset_n_o = (hold_cnt_q == '0);

  // a start while the master is busy would be ignored and the pair lost
  a_start_idle: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    spi_start_o |-> !spi_busy_i)
    else $error("spi start while master busy");

  // the transmitter takes every start it is given
  a_start_taken: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    tx_start_o |=> tx_busy_i)
    else $error("uart transmitter did not take the start");

endmodule

/* verilog/slm_bridge_top.sv */
// sys_clk is forwarded unbuffered as the slm clock; link rates are fixed by parameters only
`timescale 1ns/1ps

module slm_bridge_top #(
  parameter int CLKS_PER_BIT  = slm_bridge_pkg::DEF_CLKS_PER_BIT,
  parameter int SPI_HALF_CLKS = slm_bridge_pkg::DEF_SPI_HALF_CLKS,
  parameter int FIFO_DEPTH    = slm_bridge_pkg::DEF_FIFO_DEPTH,
  parameter int RESET_HOLD    = slm_bridge_pkg::DEF_RESET_HOLD
) (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  // host uart
  input  logic uart_rx_i,
  output logic uart_tx_o,
  // slm serial control port
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_mosi_o,
  input  logic spi_miso_i,
  // slm control lines
  output logic slm_reset_n_o,
  output logic slm_clk_o
);

  // receiver to controller
  slm_bridge_pkg::byte_t      rx_byte;
  logic                       rx_valid;
  // controller to spi master
  slm_bridge_pkg::spi_frame_t spi_frame;
  logic                       spi_start;
  logic                       spi_busy;
  slm_bridge_pkg::byte_t      spi_rx_byte;
  // reply fifo
  logic                       fifo_wr;
  logic                       fifo_rd;
  logic                       fifo_full;
  logic                       fifo_empty;
  slm_bridge_pkg::byte_t      fifo_rd_data;
  // transmitter
  logic                       tx_start;
  logic                       tx_busy;

  // slm runs straight off the system clock
  assign slm_clk_o = sys_clk;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  bridge_ctrl #(
    .RESET_HOLD (RESET_HOLD)
  ) u_ctrl (
    .sys_clk_i     (sys_clk),
    .reset_i       (reset_all_cmd_w),
    .rx_valid_i    (rx_valid),
    .rx_byte_i     (rx_byte),
    .spi_busy_i    (spi_busy),
    .spi_frame_o   (spi_frame),
    .spi_start_o   (spi_start),
    .fifo_full_i   (fifo_full),
    .fifo_empty_i  (fifo_empty),
    .fifo_wr_o     (fifo_wr),
    .fifo_rd_o     (fifo_rd),
    .tx_busy_i     (tx_busy),
    .tx_start_o    (tx_start),
    .slm_reset_n_o (slm_reset_n_o)
  );

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  // host bytes in
  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .sys_clk_i   (sys_clk),
    .reset_i     (reset_all_cmd_w),
    .rx_serial_i (uart_rx_i),
    .rx_valid_o  (rx_valid),
    .rx_byte_o   (rx_byte)
  );

  // 16-bit writes to the slm
  spi_master #(
    .SPI_HALF_CLKS (SPI_HALF_CLKS)
  ) u_spi (
    .sys_clk_i (sys_clk),
    .reset_i   (reset_all_cmd_w),
    .start_i   (spi_start),
    .frame_i   (spi_frame),
    .busy_o    (spi_busy),
    .sen_o     (spi_sen_o),
    .sck_o     (spi_sck_o),
    .mosi_o    (spi_mosi_o),
    .miso_i    (spi_miso_i),
    .rx_byte_o (spi_rx_byte)
  );

  // replies wait here while the transmitter is busy
  reply_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .sys_clk_i (sys_clk),
    .reset_i   (reset_all_cmd_w),
    .wr_en_i   (fifo_wr),
    .wr_data_i (spi_rx_byte),
    .rd_en_i   (fifo_rd),
    .rd_data_o (fifo_rd_data),
    .full_o    (fifo_full),
    .empty_o   (fifo_empty)
  );

  // replies back to the host
  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .sys_clk_i   (sys_clk),
    .reset_i     (reset_all_cmd_w),
    .tx_start_i  (tx_start),
    .tx_byte_i   (fifo_rd_data),
    .tx_busy_o   (tx_busy),
    .tx_serial_o (uart_tx_o)
  );

endmodule

/* tests/tb_slm_bridge.sv */
// runs at 16 clocks per uart bit and sck at sys_clk/4; the spi slave answers with the inverted address
`timescale 1ns/1ps

module tb_slm_bridge;

  localparam int CLKS_PER_BIT  = 16;
  localparam int SPI_HALF_CLKS = 2;
  localparam int FIFO_DEPTH    = 4;
  localparam int RESET_HOLD    = 10;
  localparam int NUM_ROWS      = 8;
  localparam int SINGLE_ROWS   = 5;
  localparam int FRAME_PULSES  = 16;
  // several uart byte times
  localparam int WAIT_LIMIT    = 25 * 10 * CLKS_PER_BIT;
  localparam int QUIET_CYCLES  = 3 * 10 * CLKS_PER_BIT;

  // one stimulus row with what the bridge must produce for it
  typedef struct packed {
    slm_bridge_pkg::byte_t addr;
    slm_bridge_pkg::byte_t data;
    logic [15:0]           exp_frame;
    slm_bridge_pkg::byte_t exp_reply;
  } row_t;

  logic sys_clk;
  logic reset_all_cmd_w;
  logic uart_rx;
  logic uart_tx;
  logic spi_sen;
  logic spi_sck;
  logic spi_mosi;
  logic spi_miso;
  logic slm_reset_n;
  logic slm_clk;

  row_t rows [NUM_ROWS];
  int   mismatch_cnt;
  int   protocol_cnt;
  int   timeout_cnt;
  int   i;

  // spi slave state
  logic                  sck_prev;
  logic                  sen_prev;
  logic [15:0]           mosi_bits;
  int                    rise_cnt;
  int                    fall_cnt;
  slm_bridge_pkg::byte_t slave_addr;
  logic [15:0]           frames_q [$];
  int                    pulses_q [$];

  // uart receive state
  logic                  mon_busy;
  int                    mon_cnt;
  int                    bit_no;
  slm_bridge_pkg::byte_t mon_byte;
  slm_bridge_pkg::byte_t replies_q [$];

  slm_bridge_top #(
    .CLKS_PER_BIT  (CLKS_PER_BIT),
    .SPI_HALF_CLKS (SPI_HALF_CLKS),
    .FIFO_DEPTH    (FIFO_DEPTH),
    .RESET_HOLD    (RESET_HOLD)
  ) u_dut (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx),
    .uart_tx_o       (uart_tx),
    .spi_sen_o       (spi_sen),
    .spi_sck_o       (spi_sck),
    .spi_mosi_o      (spi_mosi),
    .spi_miso_i      (spi_miso),
    .slm_reset_n_o   (slm_reset_n),
    .slm_clk_o       (slm_clk)
  );

  initial sys_clk = 1'b0;
  always #4 sys_clk = ~sys_clk;

  //////////////////////////////////////////////////////////////////////
  // spi slave and frame monitor
  //////////////////////////////////////////////////////////////////////

  // edges are seen and miso is driven at the falling sys_clk edge
  always @(negedge sys_clk) begin
    if (reset_all_cmd_w) begin
      sck_prev = 1'b0;
      sen_prev = 1'b1;
      spi_miso = 1'b0;
    end else begin
      // new select window
      if (sen_prev && !spi_sen) begin
        rise_cnt  = 0;
        fall_cnt  = 0;
        mosi_bits = '0;
      end
      // take mosi on rising sck
      if (!spi_sen && !sck_prev && spi_sck) begin
        mosi_bits = {mosi_bits[14:0], spi_mosi};
        rise_cnt++;
        if (rise_cnt == 8) begin
          slave_addr = mosi_bits[7:0];
        end
      end
      // next reply bit goes out msb first on falling sck
      if (!spi_sen && sck_prev && !spi_sck) begin
        fall_cnt++;
        if (fall_cnt >= 8 && fall_cnt < 16) begin
          spi_miso = ~slave_addr[15 - fall_cnt];
        end
      end
      // hand the frame over when the window closes
      if (!sen_prev && spi_sen) begin
        frames_q.push_back(mosi_bits);
        pulses_q.push_back(rise_cnt);
      end
      sck_prev = spi_sck;
      sen_prev = spi_sen;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // uart receive model
  //////////////////////////////////////////////////////////////////////

  // start is seen half a cycle in so each sample falls at count 7 + 16k
  always @(negedge sys_clk) begin
    if (reset_all_cmd_w) begin
      mon_busy = 1'b0;
    end else if (!mon_busy) begin
      if (uart_tx === 1'b0) begin
        mon_busy = 1'b1;
        mon_cnt  = 0;
      end
    end else begin
      mon_cnt++;
      if (mon_cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2 - 1) begin
        bit_no = mon_cnt / CLKS_PER_BIT;
        if (bit_no == 0 && uart_tx !== 1'b0) begin
          protocol_cnt++;
          $display("uart_tx_o start bit not low at mid-bit");
          mon_busy = 1'b0;
        end else if (bit_no >= 1 && bit_no <= 8) begin
          mon_byte[bit_no - 1] = uart_tx;
        end else if (bit_no == 9) begin
          if (uart_tx !== 1'b1) begin
            protocol_cnt++;
            $display("uart_tx_o stop bit not high at mid-bit");
          end
          replies_q.push_back(mon_byte);
          mon_busy = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tasks
  //////////////////////////////////////////////////////////////////////

  task automatic end_run();
    begin
      $display("errors: %0d mismatch, %0d protocol, %0d timeout",
               mismatch_cnt, protocol_cnt, timeout_cnt);
      if (mismatch_cnt + protocol_cnt + timeout_cnt == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  endtask

  // 8N1 frame sent lsb first from a falling edge
  task automatic send_byte(input slm_bridge_pkg::byte_t b);
    logic [9:0] line_bits;
    int         k;
    begin
      line_bits = {1'b1, b, 1'b0};
      for (k = 0; k < 10; k++) begin
        uart_rx = line_bits[k];
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
      end
    end
  endtask

  task automatic apply_reset();
    int t;
    int low_cycles;
    begin
      reset_all_cmd_w = 1'b1;
      for (t = 0; t < 10; t++) begin
        @(negedge sys_clk);
        if (spi_sen !== 1'b1) begin
          mismatch_cnt++;
          $display("Mismatch spi_sen_o in reset: got %h expected %h", spi_sen, 1'b1);
        end
        if (uart_tx !== 1'b1) begin
          mismatch_cnt++;
          $display("Mismatch uart_tx_o in reset: got %h expected %h", uart_tx, 1'b1);
        end
        if (slm_reset_n !== 1'b0) begin
          mismatch_cnt++;
          $display("Mismatch slm_reset_n_o in reset: got %h expected %h", slm_reset_n, 1'b0);
        end
      end
      reset_all_cmd_w = 1'b0;
      // count cycles until the slm reset releases
      low_cycles = 0;
      while (slm_reset_n === 1'b0 && low_cycles < 4 * RESET_HOLD) begin
        low_cycles++;
        @(negedge sys_clk);
      end
      if (slm_reset_n !== 1'b1) begin
        timeout_cnt++;
        $display("slm_reset_n_o never released after reset");
        end_run();
      end else begin
        if (low_cycles != RESET_HOLD) begin
          mismatch_cnt++;
          $display("Mismatch slm_reset_n_o low cycles: got %h expected %h",
                   low_cycles, RESET_HOLD);
        end
        if (spi_sen !== 1'b1 || uart_tx !== 1'b1) begin
          protocol_cnt++;
          $display("spi_sen_o or uart_tx_o not idle high after reset");
        end
      end
    end
  endtask

  // slm clock follows sys_clk, looked at in the middle of each phase
  task automatic check_slm_clk();
    begin
      #2;
      if (slm_clk !== 1'b0) begin
        mismatch_cnt++;
        $display("Mismatch slm_clk_o low phase: got %h expected %h", slm_clk, 1'b0);
      end
      @(posedge sys_clk);
      #2;
      if (slm_clk !== 1'b1) begin
        mismatch_cnt++;
        $display("Mismatch slm_clk_o high phase: got %h expected %h", slm_clk, 1'b1);
      end
      @(negedge sys_clk);
    end
  endtask

  task automatic check_frame(input logic [15:0] exp_frame);
    int          t;
    logic [15:0] got;
    int          pulses;
    begin
      t = 0;
      while (frames_q.size() == 0 && t < WAIT_LIMIT) begin
        @(negedge sys_clk);
        t++;
      end
      if (frames_q.size() == 0) begin
        timeout_cnt++;
        $display("no spi frame seen, expected %h", exp_frame);
        end_run();
      end else begin
        got    = frames_q.pop_front();
        pulses = pulses_q.pop_front();
        if (got !== exp_frame) begin
          mismatch_cnt++;
          $display("Mismatch spi_mosi_o frame: got %h expected %h", got, exp_frame);
        end
        if (pulses != FRAME_PULSES) begin
          mismatch_cnt++;
          $display("Mismatch spi_sck_o pulses: got %h expected %h", pulses, FRAME_PULSES);
        end
      end
    end
  endtask

  task automatic check_reply(input slm_bridge_pkg::byte_t exp_reply);
    int                    t;
    slm_bridge_pkg::byte_t got;
    begin
      t = 0;
      while (replies_q.size() == 0 && t < WAIT_LIMIT) begin
        @(negedge sys_clk);
        t++;
      end
      if (replies_q.size() == 0) begin
        timeout_cnt++;
        $display("no uart reply seen, expected %h", exp_reply);
        end_run();
      end else begin
        got = replies_q.pop_front();
        if (got !== exp_reply) begin
          mismatch_cnt++;
          $display("Mismatch uart_tx_o byte: got %h expected %h", got, exp_reply);
        end
      end
    end
  endtask

  // nothing may show up on spi during the idle stretch
  task automatic expect_no_frame(input int cycles);
    int t;
    begin
      for (t = 0; t < cycles; t++) begin
        @(negedge sys_clk);
      end
      if (frames_q.size() != 0 || spi_sen !== 1'b1) begin
        protocol_cnt++;
        $display("spi frame started without a complete byte pair");
        frames_q.delete();
        pulses_q.delete();
      end
    end
  endtask

  task automatic fill_table();
    int r;
    begin
      rows[0].addr = 8'h00;
      rows[0].data = 8'hff;
      rows[1].addr = 8'ha5;
      rows[1].data = 8'h5a;
      rows[2].addr = 8'h80;
      rows[2].data = 8'h01;
      for (r = 3; r < NUM_ROWS; r++) begin
        rows[r].addr = 8'($urandom());
        rows[r].data = 8'($urandom());
      end
      // addr goes out first and the reply is the inverted addr
      for (r = 0; r < NUM_ROWS; r++) begin
        rows[r].exp_frame = {rows[r].addr, rows[r].data};
        rows[r].exp_reply = ~rows[r].addr;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(49));
    mismatch_cnt    = 0;
    protocol_cnt    = 0;
    timeout_cnt     = 0;
    reset_all_cmd_w = 1'b1;
    uart_rx         = 1'b1;
    spi_miso        = 1'b0;
    fill_table();
    apply_reset();
    check_slm_clk();

    // one row at a time
    for (i = 0; i < SINGLE_ROWS; i++) begin
      send_byte(rows[i].addr);
      send_byte(rows[i].data);
      check_frame(rows[i].exp_frame);
      check_reply(rows[i].exp_reply);
    end

    // lone byte waits for its partner
    send_byte(8'h3c);
    expect_no_frame(QUIET_CYCLES);
    send_byte(8'hc3);
    check_frame({8'h3c, 8'hc3});
    check_reply(~8'h3c);

    // four bytes make exactly two frames
    send_byte(8'h11);
    send_byte(8'h22);
    send_byte(8'h33);
    send_byte(8'h44);
    check_frame({8'h11, 8'h22});
    check_frame({8'h33, 8'h44});
    check_reply(~8'h11);
    check_reply(~8'h33);

    // reset mid-pair clears the parity
    send_byte(8'h77);
    expect_no_frame(CLKS_PER_BIT);
    apply_reset();
    send_byte(8'h12);
    send_byte(8'h34);
    check_frame({8'h12, 8'h34});
    check_reply(~8'h12);

    // back to back rows return replies in table order
    for (i = SINGLE_ROWS; i < NUM_ROWS; i++) begin
      send_byte(rows[i].addr);
      send_byte(rows[i].data);
    end
    for (i = SINGLE_ROWS; i < NUM_ROWS; i++) begin
      check_frame(rows[i].exp_frame);
    end
    for (i = SINGLE_ROWS; i < NUM_ROWS; i++) begin
      check_reply(rows[i].exp_reply);
    end

    // nothing extra afterwards
    expect_no_frame(QUIET_CYCLES);
    if (replies_q.size() != 0) begin
      protocol_cnt++;
      $display("unexpected extra bytes on uart_tx_o: %0d", replies_q.size());
    end
    end_run();
  end

endmodule

/* all.f */
verilog/slm_bridge_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/spi_master.sv
verilog/reply_fifo.sv
verilog/bridge_ctrl.sv
verilog/slm_bridge_top.sv
tests/tb_slm_bridge.sv
